//--- rtl/pcie_app_settings.svh
`ifndef PCIE_APP_SETTINGS_SVH
`define PCIE_APP_SETTINGS_SVH

// ========================================
// stream and queue sizing
// ========================================

`define PCIE_DATA_WIDTH 128 // one beat holds three header dwords plus one data dword
`define REQ_FIFO_DEPTH 4    // decoded requests waiting for the register block
`define CPL_FIFO_DEPTH 4    // read completions waiting for the TX stream

// ========================================
// BAR0 register map
// ========================================

`define BAR0_REG_COUNT 8 // 32-bit words, index taken from address bits 4:2
`define DOORBELL_INDEX 7 // last word raises the MSI, the rest are scratch

// config sideband slot that carries bus number in 15:8 and device number in 7:3
`define CFG_BUSDEV_ADDR 5'h0f

`endif

//--- rtl/pcie_app_pkg.sv
`default_nettype none

package pcie_app_pkg;

    // ========================================
    // TLP format and type codes
    // ========================================

    // fmt in bits 7:5 and type in bits 4:0, as found in the top byte of dword 0
    typedef enum logic [7:0] {
        TLP_MRD32 = 8'h00, // 3 dword header, no data
        TLP_MWR32 = 8'h40, // 3 dword header with data
        TLP_CPLD  = 8'h4a  // completion with data
    } tlp_kind_e;

    // ========================================
    // records passed between the blocks
    // ========================================

    // one decoded BAR0 access, reads and writes share the same record
    typedef struct packed {
        logic        wr;         // set for a memory write, clear for a read
        logic [2:0]  idx;        // register word index
        logic [31:0] data;       // write data, don't care on reads
        logic [15:0] req_id;     // requester bus, device and function
        logic [7:0]  tag;
        logic [6:0]  lower_addr; // echoed back in the completion
    } bar_req_t;

    // everything cpl_gen needs to build a CplD beat, except the completer ID
    typedef struct packed {
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [6:0]  lower_addr;
        logic [31:0] data; // read data for the one dword returned
    } bar_cpl_t;

endpackage

`default_nettype wire

//--- rtl/tlp_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module tlp_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire      clk,
    input  wire      arst_n,

    input  wire payload_t in_data,
    input  wire      in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  wire      out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH]; // storage holds no reset, count says what is live
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign in_ready  = count != CNT_W'(DEPTH); // full only when every slot is taken
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr]; // head entry is visible the cycle after its push

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the fill level alone
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_req_parser.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module rx_req_parser (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire [`PCIE_DATA_WIDTH-1:0]  rx_st_data,
    input  wire                         rx_st_sop,
    input  wire                         rx_st_eop,
    input  wire                         rx_st_valid,
    output logic                        rx_st_ready,

    output pcie_app_pkg::bar_req_t      req,
    output logic                        req_valid,
    input  wire                         req_ready
);

    import pcie_app_pkg::*;

    // ========================================
    // header field extraction
    // ========================================

    logic [31:0] dw0; // fmt/type and length
    logic [31:0] dw1; // requester ID, tag, byte enables
    logic [31:0] dw2; // 32-bit address
    logic [31:0] dw3; // write payload, padding on reads
    logic [7:0]  fmt_type;
    logic [9:0]  length;
    logic        is_wr;
    logic        is_rd;
    logic        supported;
    logic        beat;
    logic        ready_en; // holds the stream off until the first cycle after reset

    assign dw0 = rx_st_data[31:0];
    assign dw1 = rx_st_data[63:32];
    assign dw2 = rx_st_data[95:64];
    assign dw3 = rx_st_data[127:96];

    assign fmt_type = dw0[31:24];
    assign length   = dw0[9:0];

    assign is_wr = fmt_type == TLP_MWR32;
    assign is_rd = fmt_type == TLP_MRD32;

    // only single-beat, single-dword accesses become requests, the rest are eaten
    assign supported = rx_st_sop && rx_st_eop && (is_wr || is_rd) && length == 10'd1;

    // take a beat when the output register is free or drains in this cycle
    assign rx_st_ready = ready_en && (!req_valid || req_ready);
    assign beat        = rx_st_valid && rx_st_ready;

    // ========================================
    // output register
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_en  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (beat && supported) begin
                req_valid <= 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0; // drained, or a dropped beat leaves it empty
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat && supported) begin
            req.wr         <= is_wr;
            req.idx        <= dw2[4:2]; // word index inside BAR0
            req.data       <= dw3;
            req.req_id     <= dw1[31:16];
            req.tag        <= dw1[15:8];
            req.lower_addr <= dw2[6:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/bar_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module bar_regs (
    input  wire                     clk,
    input  wire                     arst_n,

    input  wire pcie_app_pkg::bar_req_t req,
    input  wire                     req_valid,
    output logic                    req_ready,

    output pcie_app_pkg::bar_cpl_t  cpl,
    output logic                    cpl_valid,
    input  wire                     cpl_ready,

    output logic                    app_msi_req,
    output logic [4:0]              app_msi_num,
    input  wire                     app_msi_ack,

    input  wire [31:0]              tl_cfg_ctl,
    input  wire [4:0]               tl_cfg_add,
    output logic [15:0]             completer_id
);

    logic [31:0] scratch [`BAR0_REG_COUNT-1]; // every word below the doorbell
    logic [31:0] rd_data;
    logic        is_db;
    logic        pop;

    assign is_db = req.idx == 3'(`DOORBELL_INDEX);

    // writes never need the completion path, reads wait for room behind the cpl register
    assign req_ready = req.wr || !cpl_valid || cpl_ready;
    assign pop       = req_valid && req_ready;

    // ========================================
    // register file
    // ========================================

    always_ff @(posedge clk) begin
        if (pop && req.wr && !is_db) begin
            scratch[req.idx] <= req.data;
        end
    end

    // doorbell reads back the pending flag in bit 0 and the number in 12:8
    always_comb begin
        if (is_db) begin
            rd_data = {19'd0, app_msi_num, 7'd0, app_msi_req};
        end else begin
            rd_data = scratch[req.idx];
        end
    end

    // ========================================
    // MSI doorbell
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            app_msi_req <= 1'b0;
            app_msi_num <= 5'd0;
        end else begin
            if (app_msi_req && app_msi_ack) begin
                app_msi_req <= 1'b0; // hard IP has taken it
            end else if (pop && req.wr && is_db && !app_msi_req) begin
                app_msi_req <= 1'b1;
                app_msi_num <= req.data[4:0];
            end
            // a doorbell write while one is pending falls through and is lost
        end
    end

    // ========================================
    // completion register
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cpl_valid <= 1'b0;
        end else if (pop && !req.wr) begin
            cpl_valid <= 1'b1;
        end else if (cpl_ready) begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !req.wr) begin
            cpl.req_id     <= req.req_id;
            cpl.tag        <= req.tag;
            cpl.lower_addr <= req.lower_addr;
            cpl.data       <= rd_data; // sampled in request order, so earlier writes are seen
        end
    end

    // bus and device come from the config sideband, function is always 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            completer_id <= 16'd0;
        end else if (tl_cfg_add == `CFG_BUSDEV_ADDR) begin
            completer_id <= {tl_cfg_ctl[15:8], tl_cfg_ctl[7:3], 3'd0};
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpl_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module cpl_gen (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire pcie_app_pkg::bar_cpl_t cpl,
    input  wire                         cpl_valid,
    output logic                        cpl_ready,
    input  wire [15:0]                  completer_id,

    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    output logic                        tx_st_err,
    input  wire                         tx_st_ready
);

    import pcie_app_pkg::*;

    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;

    // ========================================
    // CplD header
    // ========================================

    assign dw0 = {TLP_CPLD, 14'd0, 10'd1};            // no TC or attributes, one dword
    assign dw1 = {completer_id, 3'b000, 1'b0, 12'd4}; // successful, byte count 4
    assign dw2 = {cpl.req_id, cpl.tag, 1'b0, cpl.lower_addr};

    // next record loads when the beat is empty or leaves in this cycle
    assign cpl_ready = !tx_st_valid || tx_st_ready;

    // every completion fits one beat, so sop and eop simply follow valid
    assign tx_st_sop = tx_st_valid;
    assign tx_st_eop = tx_st_valid;
    assign tx_st_err = 1'b0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_st_valid <= 1'b0;
        end else if (cpl_valid && cpl_ready) begin
            tx_st_valid <= 1'b1;
        end else if (tx_st_ready) begin
            tx_st_valid <= 1'b0;
        end
    end

    // beat only changes on a load, so it stays put while tx_st_ready is low
    always_ff @(posedge clk) begin
        if (cpl_valid && cpl_ready) begin
            tx_st_data <= {cpl.data, dw2, dw1, dw0};
        end
    end

endmodule

`default_nettype wire

//--- rtl/example_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module example_core (
    input  wire                         clk,
    input  wire                         arst_n,

    // RX stream from the hard IP
    input  wire [`PCIE_DATA_WIDTH-1:0]  rx_st_data,
    input  wire                         rx_st_sop,
    input  wire                         rx_st_eop,
    input  wire                         rx_st_valid,
    output logic                        rx_st_ready,

    // TX stream to the hard IP
    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    output logic                        tx_st_err,
    input  wire                         tx_st_ready,

    output logic                        app_msi_req,
    output logic [4:0]                  app_msi_num,
    input  wire                         app_msi_ack,

    input  wire [31:0]                  tl_cfg_ctl,
    input  wire [4:0]                   tl_cfg_add
);

    import pcie_app_pkg::*;

    // ========================================
    // internal links
    // ========================================

    bar_req_t    parsed_req;  // parser to request queue
    logic        parsed_valid;
    logic        parsed_ready;
    bar_req_t    queued_req;  // request queue to register block
    logic        queued_valid;
    logic        queued_ready;
    bar_cpl_t    reg_cpl;     // register block to completion queue
    logic        reg_cpl_valid;
    logic        reg_cpl_ready;
    bar_cpl_t    queued_cpl;  // completion queue to TX beat builder
    logic        queued_cpl_valid;
    logic        queued_cpl_ready;
    logic [15:0] completer_id;

    rx_req_parser rx_req_parser_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_st_data  (rx_st_data),
        .rx_st_sop   (rx_st_sop),
        .rx_st_eop   (rx_st_eop),
        .rx_st_valid (rx_st_valid),
        .rx_st_ready (rx_st_ready),
        .req         (parsed_req),
        .req_valid   (parsed_valid),
        .req_ready   (parsed_ready)
    );

    tlp_fifo #(
        .payload_t (bar_req_t),
        .DEPTH     (`REQ_FIFO_DEPTH)
    ) req_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (parsed_req),
        .in_valid  (parsed_valid),
        .in_ready  (parsed_ready),
        .out_data  (queued_req),
        .out_valid (queued_valid),
        .out_ready (queued_ready)
    );

    bar_regs bar_regs_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (queued_req),
        .req_valid    (queued_valid),
        .req_ready    (queued_ready),
        .cpl          (reg_cpl),
        .cpl_valid    (reg_cpl_valid),
        .cpl_ready    (reg_cpl_ready),
        .app_msi_req  (app_msi_req),
        .app_msi_num  (app_msi_num),
        .app_msi_ack  (app_msi_ack),
        .tl_cfg_ctl   (tl_cfg_ctl),
        .tl_cfg_add   (tl_cfg_add),
        .completer_id (completer_id)
    );

    tlp_fifo #(
        .payload_t (bar_cpl_t),
        .DEPTH     (`CPL_FIFO_DEPTH)
    ) cpl_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (reg_cpl),
        .in_valid  (reg_cpl_valid),
        .in_ready  (reg_cpl_ready),
        .out_data  (queued_cpl),
        .out_valid (queued_cpl_valid),
        .out_ready (queued_cpl_ready)
    );

    cpl_gen cpl_gen_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .cpl          (queued_cpl),
        .cpl_valid    (queued_cpl_valid),
        .cpl_ready    (queued_cpl_ready),
        .completer_id (completer_id),
        .tx_st_data   (tx_st_data),
        .tx_st_sop    (tx_st_sop),
        .tx_st_eop    (tx_st_eop),
        .tx_st_valid  (tx_st_valid),
        .tx_st_err    (tx_st_err),
        .tx_st_ready  (tx_st_ready)
    );

endmodule

`default_nettype wire

//--- rtl/fpga_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module fpga_core (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire [`PCIE_DATA_WIDTH-1:0]  rx_st_data,
    input  wire                         rx_st_sop,
    input  wire                         rx_st_eop,
    input  wire                         rx_st_valid,
    output logic                        rx_st_ready,

    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    output logic                        tx_st_err,
    input  wire                         tx_st_ready,

    output logic                        app_msi_req,
    input  wire                         app_msi_ack,
    output logic [2:0]                  app_msi_tc,
    output logic [4:0]                  app_msi_num,
    output logic [1:0]                  app_msi_func_num,

    input  wire [31:0]                  tl_cfg_ctl,
    input  wire [4:0]                   tl_cfg_add
);

    // single function, interrupts always go out on traffic class 0
    assign app_msi_tc       = 3'd0;
    assign app_msi_func_num = 2'd0;

    example_core example_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_st_data  (rx_st_data),
        .rx_st_sop   (rx_st_sop),
        .rx_st_eop   (rx_st_eop),
        .rx_st_valid (rx_st_valid),
        .rx_st_ready (rx_st_ready),
        .tx_st_data  (tx_st_data),
        .tx_st_sop   (tx_st_sop),
        .tx_st_eop   (tx_st_eop),
        .tx_st_valid (tx_st_valid),
        .tx_st_err   (tx_st_err),
        .tx_st_ready (tx_st_ready),
        .app_msi_req (app_msi_req),
        .app_msi_num (app_msi_num),
        .app_msi_ack (app_msi_ack),
        .tl_cfg_ctl  (tl_cfg_ctl),
        .tl_cfg_add  (tl_cfg_add)
    );

endmodule

`default_nettype wire

//--- dv/fpga_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module fpga_core_chk (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         rx_st_ready,
    input  wire [`PCIE_DATA_WIDTH-1:0]  tx_st_data,
    input  wire                         tx_st_sop,
    input  wire                         tx_st_eop,
    input  wire                         tx_st_valid,
    input  wire                         tx_st_err,
    input  wire                         tx_st_ready,
    input  wire                         app_msi_req,
    input  wire [4:0]                   app_msi_num,
    input  wire                         app_msi_ack
);

    int unsigned fail_count = 0; // the testbench adds this to its own error count

    // ========================================
    // TX stream rules
    // ========================================

    // a stalled beat must still be there, unchanged, on the next edge
    tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_st_valid && !tx_st_ready |=> tx_st_valid && $stable(tx_st_data))
        else begin
            $error("TX beat changed or was withdrawn while tx_st_ready was low");
            fail_count++;
        end

    // every completion is a single beat and is never flagged as bad
    tx_single: assert property (@(posedge clk) disable iff (!arst_n)
        tx_st_valid |-> tx_st_sop && tx_st_eop && !tx_st_err)
        else begin
            $error("TX beat without sop and eop, or with tx_st_err set");
            fail_count++;
        end

    // ========================================
    // MSI and reset rules
    // ========================================

    msi_hold: assert property (@(posedge clk) disable iff (!arst_n)
        app_msi_req && !app_msi_ack |=> app_msi_req && $stable(app_msi_num))
        else begin
            $error("MSI request dropped or its number changed before the ack");
            fail_count++;
        end

    // no handshake may be offered while the core sits in reset
    reset_idle: assert property (@(posedge clk)
        !arst_n |-> !rx_st_ready && !tx_st_valid && !app_msi_req)
        else begin
            $error("an output was active while reset was asserted");
            fail_count++;
        end

endmodule

bind fpga_core fpga_core_chk fpga_core_chk_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .rx_st_ready (rx_st_ready),
    .tx_st_data  (tx_st_data),
    .tx_st_sop   (tx_st_sop),
    .tx_st_eop   (tx_st_eop),
    .tx_st_valid (tx_st_valid),
    .tx_st_err   (tx_st_err),
    .tx_st_ready (tx_st_ready),
    .app_msi_req (app_msi_req),
    .app_msi_num (app_msi_num),
    .app_msi_ack (app_msi_ack)
);

`default_nettype wire

//--- dv/tb_fpga_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "pcie_app_settings.svh"

module tb_fpga_core;

    localparam int         MAX_CYCLES = 4000; // about ten times the length of all tests
    localparam logic [7:0] MWR32      = 8'h40;
    localparam logic [7:0] MRD32      = 8'h00;
    localparam logic [7:0] MRD64      = 8'h20; // legal TLP, but not one this core serves
    localparam logic [7:0] CPLD       = 8'h4a;
    localparam logic [7:0] CFG_BUS    = 8'h5a;
    localparam logic [4:0] CFG_DEV    = 5'h13;

    logic                        clk;
    logic                        arst_n;
    logic [`PCIE_DATA_WIDTH-1:0] rx_st_data;
    logic                        rx_st_sop;
    logic                        rx_st_eop;
    logic                        rx_st_valid;
    logic                        rx_st_ready;
    logic [`PCIE_DATA_WIDTH-1:0] tx_st_data;
    logic                        tx_st_sop;
    logic                        tx_st_eop;
    logic                        tx_st_valid;
    logic                        tx_st_err;
    logic                        tx_st_ready;
    logic                        app_msi_req;
    logic                        app_msi_ack;
    logic [2:0]                  app_msi_tc;
    logic [4:0]                  app_msi_num;
    logic [1:0]                  app_msi_func_num;
    logic [31:0]                 tl_cfg_ctl;
    logic [4:0]                  tl_cfg_add;

    int unsigned  errors;
    int unsigned  cycles;
    int unsigned  rx_stalls;            // cycles a beat waited on rx_st_ready
    int unsigned  tx_mode;              // 0 always ready, 1 random stalls, 2 held off
    logic [31:0]  regs_model [8];       // scratch words as the host expects them
    logic [127:0] expected_q [$];       // CplD beats owed, oldest first
    logic [127:0] expected_beat;

    fpga_core i_fpga_core (.*);

    always #20 clk = ~clk; // 40 ns period

    // ========================================
    // TLP builders and checks
    // ========================================

    // MWr32/MRd32 request beat, dword 0 sits in the low bits
    function automatic logic [127:0] rx_beat(input logic [7:0] fmt_type, input logic [9:0] length,
            input logic [15:0] req_id, input logic [7:0] tag, input logic [31:0] addr,
            input logic [31:0] data);
        return {data, addr, req_id, tag, 8'h0f, fmt_type, 14'd0, length};
    endfunction

    // successful one-dword CplD with byte count 4, completer function always 0
    function automatic logic [127:0] cpld_beat(input logic [15:0] req_id, input logic [7:0] tag,
            input logic [6:0] lower_addr, input logic [31:0] data);
        return {data, req_id, tag, 1'b0, lower_addr, CFG_BUS, CFG_DEV, 3'b000, 3'b000, 1'b0,
                12'd4, CPLD, 14'd0, 10'd1};
    endfunction

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // called 2 ns after an edge and returns 2 ns after the edge that took the beat
    task automatic send_beat(input logic [127:0] data, input logic sop, input logic eop);
        logic taken;
        rx_st_data  = data;
        rx_st_sop   = sop;
        rx_st_eop   = eop;
        rx_st_valid = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            #1;
            taken = rx_st_ready; // settled well before the coming edge
            if (!taken) rx_stalls++;
            @(posedge clk);
            #2;
        end
        rx_st_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [31:0] data);
        logic [31:0] rnd;
        rnd = $urandom();
        send_beat(rx_beat(MWR32, 10'd1, rnd[15:0], rnd[23:16], {rnd[31:5], idx, 2'b00}, data),
                  1'b1, 1'b1);
        if (idx != 3'(`DOORBELL_INDEX)) regs_model[idx] = data; // doorbell has no storage
    endtask

    // the CplD is queued first, so it can never arrive before it is expected
    task automatic read_reg(input logic [2:0] idx, input logic [31:0] exp_data);
        logic [31:0] rnd;
        logic [31:0] addr;
        rnd  = $urandom();
        addr = {rnd[31:5], idx, 2'b00};
        expected_q.push_back(cpld_beat(rnd[15:0], rnd[23:16], addr[6:0], exp_data));
        send_beat(rx_beat(MRD32, 10'd1, rnd[15:0], rnd[23:16], addr, 32'd0), 1'b1, 1'b1);
    endtask

    task automatic wait_completions();
        while (expected_q.size() != 0) @(posedge clk);
        #2;
    endtask

    // ========================================
    // TX side, watchdog
    // ========================================

    always @(posedge clk) begin
        #2;
        case (tx_mode)
            0:       tx_st_ready = 1'b1;
            1:       tx_st_ready = ($urandom() % 4) != 0; // roughly one stall in four
            default: tx_st_ready = 1'b0;
        endcase
    end

    // valid and ready are both steady at the falling edge, the beat moves on the next rise
    always @(negedge clk) begin
        if (arst_n && tx_st_valid && tx_st_ready) begin
            assert (expected_q.size() != 0) else begin
                $display("ERROR %0t: completion arrived with no read outstanding", $time);
                errors++;
            end
            if (expected_q.size() != 0) begin
                expected_beat = expected_q.pop_front();
                assert (tx_st_data === expected_beat) else begin
                    $display("ERROR %0t: CplD is %h, expected %h", $time, tx_st_data,
                             expected_beat);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d completions never arrived", cycles,
                     expected_q.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin
        logic [4:0]  msi_num;
        logic [31:0] data;
        logic [2:0]  idx;
        void'($urandom(32'h2f843193));
        clk         = 1'b0;
        arst_n      = 1'b1;
        rx_st_data  = '0;
        rx_st_sop   = 1'b0;
        rx_st_eop   = 1'b0;
        rx_st_valid = 1'b0;
        tx_st_ready = 1'b1;
        app_msi_ack = 1'b0;
        tl_cfg_ctl  = 32'd0;
        tl_cfg_add  = 5'd0;
        errors      = 0;
        cycles      = 0;
        rx_stalls   = 0;
        tx_mode     = 0;
        #1;
        arst_n = 1'b0; // a clean falling edge clears every flop at once
        repeat (8) @(posedge clk);
        #2;
        expect_equal(32'(rx_st_ready), 32'd0, "rx_st_ready in reset");
        arst_n     = 1'b1;
        tl_cfg_add = `CFG_BUSDEV_ADDR; // junk around the bus and device fields
        tl_cfg_ctl = {16'hdead, CFG_BUS, CFG_DEV, 3'b101};
        @(posedge clk);
        #2;
        expect_equal(32'(rx_st_ready), 32'd1, "rx_st_ready one cycle after reset");
        expect_equal(32'(tx_st_valid), 32'd0, "tx_st_valid after reset");
        expect_equal(32'(app_msi_req), 32'd0, "app_msi_req after reset");
        tl_cfg_add = 5'd0; // other slots must leave the completer ID alone
        tl_cfg_ctl = $urandom();

        // scratch writes, each read straight back
        repeat (10) begin
            idx  = 3'($urandom() % 7);
            data = $urandom();
            write_reg(idx, data);
            read_reg(idx, regs_model[idx]);
        end
        wait_completions();

        // read burst against a TX side that first holds off, then stalls at random
        for (int i = 0; i < 7; i++) write_reg(3'(i), $urandom());
        rx_stalls = 0;
        tx_mode   = 2;
        fork
            for (int i = 0; i < 12; i++) read_reg(3'(i % 7), regs_model[i % 7]);
            begin
                repeat (20) @(posedge clk);
                tx_mode = 1;
            end
        join
        wait_completions();
        assert (rx_stalls != 0) else begin
            $display("ERROR %0t: rx_st_ready never dropped during the read burst", $time);
            errors++;
        end

        // unsupported and two-beat TLPs are eaten, reg 3 must keep its value
        data = $urandom();
        write_reg(3'd3, data);
        send_beat(rx_beat(MRD64, 10'd1, 16'h0100, 8'h21, 32'h0000_000c, 32'd0), 1'b1, 1'b1);
        send_beat(rx_beat(MWR32, 10'd2, 16'h0100, 8'h22, 32'h0000_000c, ~data), 1'b1, 1'b1);
        send_beat(rx_beat(MWR32, 10'd1, 16'h0100, 8'h23, 32'h0000_000c, ~data), 1'b1, 1'b0);
        send_beat({4{$urandom()}}, 1'b0, 1'b1);
        read_reg(3'd3, regs_model[3]);
        wait_completions();

        // doorbell, a second ring before the ack is lost
        msi_num = 5'($urandom());
        write_reg(3'(`DOORBELL_INDEX), {27'($urandom()), msi_num});
        while (!app_msi_req) begin
            @(posedge clk);
            #2;
        end
        expect_equal(32'(app_msi_num), 32'(msi_num), "app_msi_num");
        expect_equal(32'(app_msi_tc), 32'd0, "app_msi_tc");
        expect_equal(32'(app_msi_func_num), 32'd0, "app_msi_func_num");
        write_reg(3'(`DOORBELL_INDEX), {27'd0, ~msi_num});
        read_reg(3'(`DOORBELL_INDEX), {19'd0, msi_num, 7'd0, 1'b1});
        wait_completions();
        expect_equal(32'(app_msi_num), 32'(msi_num), "app_msi_num after second ring");
        repeat (1 + $urandom() % 6) @(posedge clk); // hard IP takes its time to ack
        #2;
        app_msi_ack = 1'b1;
        @(posedge clk);
        #2;
        app_msi_ack = 1'b0;
        expect_equal(32'(app_msi_req), 32'd0, "app_msi_req after ack");
        read_reg(3'(`DOORBELL_INDEX), {19'd0, msi_num, 7'd0, 1'b0});
        wait_completions();

        repeat (4) @(posedge clk);
        errors += i_fpga_core.fpga_core_chk_inst.fail_count;
        $display("run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/pcie_app_pkg.sv
rtl/tlp_fifo.sv
rtl/rx_req_parser.sv
rtl/bar_regs.sv
rtl/cpl_gen.sv
rtl/example_core.sv
rtl/fpga_core.sv
dv/fpga_core_chk.sv
dv/tb_fpga_core.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_fpga_core
FILELIST  := src.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
# keep running past a failed assertion so the testbench can count it
RUN_FLAGS := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@if grep -qx "Result: PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
